//--- issue_vectors.txt
# fu op rs1 rs2 rd imm pc tid flags(imm,pc,zimm,ex,c) valid clob_reg clob_fu clob_reg clob_fu
# fwd1 fwd1_v fwd2 fwd2_v flu lsu we0 a0 d0 we1 a1 d1 flush exp_ack exp_strobes(alu,br,mul,csr,lsu)
0 0 00 00 00 00000000 00000000 0 00 0 00 0 00 0 00000000 0 00000000 0 1 1 1 01 11111111 1 02 22222222 0 0 00
0 0 00 00 00 00000000 00000000 0 00 0 00 0 00 0 00000000 0 00000000 0 1 1 1 00 deadbeef 1 03 33333333 0 0 00
1 0 01 02 05 00000000 00001000 1 00 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 10
1 0 00 03 06 00000000 00001004 2 00 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 10
1 0 01 02 07 00000000 00001008 3 00 1 01 1 02 5 aaaa0001 1 bbbb0002 1 1 1 0 00 00000000 0 00 00000000 0 1 10
1 0 01 00 08 00000000 0000100c 4 00 1 01 4 00 0 aaaa0001 1 00000000 0 1 1 0 00 00000000 0 00 00000000 0 0 00
4 a 01 02 00 00000000 00001010 5 00 1 01 4 00 0 cccc0003 1 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 02
1 0 01 02 08 00000000 00001014 6 00 1 02 1 00 0 00000000 0 dddd0004 0 1 1 0 00 00000000 0 00 00000000 0 0 00
1 0 01 02 09 00000000 00001018 7 00 1 09 3 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 0 00
1 0 01 02 09 00000000 0000101c 7 00 1 09 3 00 0 00000000 0 00000000 0 1 1 1 09 99999999 0 00 00000000 0 1 10
1 0 01 02 0a 00000000 00001020 0 00 1 00 0 00 0 00000000 0 00000000 0 0 1 0 00 00000000 0 00 00000000 0 0 00
5 5 09 00 0a 00000010 00001024 1 10 1 00 0 00 0 00000000 0 00000000 0 1 0 0 00 00000000 0 00 00000000 0 0 00
5 5 09 00 0a 00000010 00001024 1 10 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 01
3 4 01 02 0b 00000000 00001028 2 00 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 04
1 0 01 02 0c 00000000 0000102c 3 00 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 0 00
1 0 01 02 0c 00000000 0000102c 3 00 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 10
1 0 01 02 0d 00000000 00002000 4 08 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 10
4 9 15 00 01 00000000 00002004 5 04 1 15 1 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 02
6 6 01 02 00 00000044 00002008 6 10 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 01
2 7 01 03 00 00000080 0000200c 7 10 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 08
1 0 01 02 0e 00000123 00002010 0 10 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 10
1 0 01 02 0f 00000000 00002014 1 02 1 01 4 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 00
0 0 00 02 00 00000000 00002018 2 00 1 02 1 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 00
1 0 01 02 10 00000000 0000201c 3 00 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 1 1 00
1 0 01 02 10 00000000 00002020 4 00 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 10
3 4 01 02 11 00000000 00002024 5 00 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 1 1 00
1 0 01 02 12 00000000 00002028 6 00 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 10
4 9 07 00 13 00000000 00003000 7 0c 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 02
1 0 01 02 14 00000000 00003004 0 01 1 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 1 10
0 0 00 00 00 00000000 00000000 0 00 0 00 0 00 0 00000000 0 00000000 0 1 1 0 00 00000000 0 00 00000000 0 0 00

//--- compile.f
issue_pkg.sv
gpr_regfile.sv
issue_hazard_check.sv
operand_dispatch.sv
issue_read_operands.sv
tb_clk_gen.sv
tb_issue.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_issue \
  -f compile.f -o tb_issue_sim

./obj_dir/tb_issue_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
else
  exit 1
fi

//--- tb_issue.sv
/*
 * testbench for the issue and operand-read stage
 * reads stimulus and expected ack/strobes from issue_vectors.txt
 * keeps a register model and predicts operands, pc and flags
 */

`timescale 1ns/1ps

module tb_issue import issue_pkg::*; ();

  localparam int unsigned NR_COMMIT      = 2;
  localparam int unsigned TIMEOUT_CYCLES = 20;
  localparam int unsigned NR_FIELDS      = 29;

  logic                          clk;
  logic                          rst_n;
  logic                          flush;
  issue_instr_t                  instr;
  logic                          instr_valid;
  logic                          ack;
  fu_t          [NR_REGS-1:0]    clobber;
  logic         [XLEN-1:0]       rs1_fwd;
  logic                          rs1_fwd_valid;
  logic         [XLEN-1:0]       rs2_fwd;
  logic                          rs2_fwd_valid;
  commit_port_t [NR_COMMIT-1:0]  commit;
  logic                          flu_ready;
  logic                          lsu_ready;
  fu_data_t                      fu_data;
  fu_valid_t                     fu_valid;
  logic         [XLEN-1:0]       pc;
  logic                          is_compressed;

  // reference copy of the architectural registers
  logic [XLEN-1:0] reg_model [NR_REGS];
  logic [31:0]     f [NR_FIELDS];
  int unsigned     errors;
  int unsigned     checks;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  issue_read_operands #(
    .NrCommitPorts (NR_COMMIT)
  ) DUT (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .flush_i               (flush),
    .issue_instr_i         (instr),
    .issue_instr_valid_i   (instr_valid),
    .issue_ack_o           (ack),
    .rd_clobber_i          (clobber),
    .rs1_fwd_i             (rs1_fwd),
    .rs1_fwd_valid_i       (rs1_fwd_valid),
    .rs2_fwd_i             (rs2_fwd),
    .rs2_fwd_valid_i       (rs2_fwd_valid),
    .commit_i              (commit),
    .flu_ready_i           (flu_ready),
    .lsu_ready_i           (lsu_ready),
    .fu_data_o             (fu_data),
    .fu_valid_o            (fu_valid),
    .pc_o                  (pc),
    .is_compressed_instr_o (is_compressed)
  );

  // ------------------------------
  // helpers
  // ------------------------------
  // scoreboard value usable unless a CSR owns it (sfence.vma excepted)
  function automatic logic forward_allowed(fu_t owner, logic fwd_valid, fu_op_t op);
    return (owner != NONE) && fwd_valid && ((owner != CSR) || (op == SFENCE_VMA));
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // load one parsed vector onto the DUT inputs
  task automatic drive_vector();
    instr.fu            = fu_t'(f[0][2:0]);
    instr.op            = fu_op_t'(f[1][3:0]);
    instr.rs1           = f[2][4:0];
    instr.rs2           = f[3][4:0];
    instr.rd            = f[4][4:0];
    instr.imm           = f[5];
    instr.pc            = f[6];
    instr.trans_id      = f[7][2:0];
    instr.use_imm       = f[8][4];
    instr.use_pc        = f[8][3];
    instr.use_zimm      = f[8][2];
    instr.ex_valid      = f[8][1];
    instr.is_compressed = f[8][0];
    instr_valid         = f[9][0];
    for (int i = 0; i < NR_REGS; i++) begin
      clobber[i] = NONE;
    end
    clobber[f[10][4:0]] = fu_t'(f[11][2:0]);
    clobber[f[12][4:0]] = fu_t'(f[13][2:0]);
    rs1_fwd         = f[14];
    rs1_fwd_valid   = f[15][0];
    rs2_fwd         = f[16];
    rs2_fwd_valid   = f[17][0];
    flu_ready       = f[18][0];
    lsu_ready       = f[19][0];
    commit[0].we    = f[20][0];
    commit[0].waddr = f[21][4:0];
    commit[0].wdata = f[22];
    commit[1].we    = f[23][0];
    commit[1].waddr = f[24][4:0];
    commit[1].wdata = f[25];
    flush           = f[26][0];
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin : main
    int          fd;
    int          n;
    int          r;
    int unsigned wait_cnt;
    string       line;
    logic [31:0] exp_a;
    logic [31:0] exp_b;

    errors        = 0;
    checks        = 0;
    flush         = 1'b0;
    instr         = '0;
    instr_valid   = 1'b0;
    clobber       = '0;
    rs1_fwd       = '0;
    rs1_fwd_valid = 1'b0;
    rs2_fwd       = '0;
    rs2_fwd_valid = 1'b0;
    commit        = '0;
    flu_ready     = 1'b0;
    lsu_ready     = 1'b0;
    for (int i = 0; i < NR_REGS; i++) begin
      reg_model[i] = '0;
    end

    fd = $fopen("issue_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open issue_vectors.txt");
      $display("STATUS: FAIL");
      $finish;
    end

    // wait for reset release
    wait_cnt = 0;
    while (!rst_n && (wait_cnt < TIMEOUT_CYCLES)) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!rst_n) begin
      $display("timeout waiting for reset release");
      $display("STATUS: FAIL");
      $finish;
    end

    while (!$feof(fd)) begin
      r = $fgets(line, fd);
      // skip blank and comment lines
      if ((r == 0) || (line.len() < 8) || (line.getc(0) == "#")) begin
        continue;
      end
      n = $sscanf(line,
        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12],
        f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23],
        f[24], f[25], f[26], f[27], f[28]);
      if (n != NR_FIELDS) begin
        errors++;
        $display("vector line has %0d fields instead of %0d: %s", n, NR_FIELDS, line);
        continue;
      end

      @(negedge clk);
      drive_vector();

      // operands predicted from the register state before this edge
      if (instr.use_zimm) begin
        exp_a = {{(XLEN - REG_ADDR_W){1'b0}}, instr.rs1};
      end else if (instr.use_pc) begin
        exp_a = instr.pc;
      end else if (forward_allowed(clobber[instr.rs1], rs1_fwd_valid, instr.op)) begin
        exp_a = rs1_fwd;
      end else begin
        exp_a = reg_model[instr.rs1];
      end
      if (instr.use_imm && (instr.fu != STORE) && (instr.fu != CTRL_FLOW)) begin
        exp_b = instr.imm;
      end else if (forward_allowed(clobber[instr.rs2], rs2_fwd_valid, instr.op)) begin
        exp_b = rs2_fwd;
      end else begin
        exp_b = reg_model[instr.rs2];
      end

      // ack is combinational, sample just before the rising edge
      #3;
      compare_word("issue_ack_o", {31'b0, ack}, {31'b0, f[27][0]});

      @(posedge clk);
      for (int p = 0; p < NR_COMMIT; p++) begin
        if (commit[p].we && (commit[p].waddr != '0)) begin
          reg_model[commit[p].waddr] = commit[p].wdata;
        end
      end
      #1;
      compare_word("fu_valid_o", {27'b0, fu_valid}, {27'b0, f[28][4:0]});
      compare_word("fu_data_o.fu", {29'b0, fu_data.fu}, {29'b0, f[0][2:0]});
      compare_word("fu_data_o.operation", {28'b0, fu_data.operation}, {28'b0, f[1][3:0]});
      compare_word("fu_data_o.operand_a", fu_data.operand_a, exp_a);
      compare_word("fu_data_o.operand_b", fu_data.operand_b, exp_b);
      compare_word("fu_data_o.imm", fu_data.imm, f[5]);
      compare_word("fu_data_o.trans_id", {29'b0, fu_data.trans_id}, {29'b0, f[7][2:0]});
      compare_word("pc_o", pc, f[6]);
      compare_word("is_compressed_instr_o", {31'b0, is_compressed}, {31'b0, f[8][0]});
    end
    $fclose(fd);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // overall guard in case the vector loop stalls
  initial begin : watchdog
    #100000;
    $display("simulation ran too long, stopped by watchdog");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- tb_clk_gen.sv
/*
 * testbench clock and reset source
 * 8 ns clock, active-low reset held for 4 cycles
 */

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 8,
  parameter int unsigned RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // free-running clock, starts low
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- issue_read_operands.sv
/*
 * issue and operand-read stage, top level
 * register file and hazard check side by side, feeding dispatch
 */

`timescale 1ns/1ps

module issue_read_operands import issue_pkg::*; #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  // decode
  input  issue_instr_t                      issue_instr_i,
  input  logic                              issue_instr_valid_i,
  output logic                              issue_ack_o,
  // scoreboard
  input  fu_t          [NR_REGS-1:0]        rd_clobber_i,
  input  logic         [XLEN-1:0]           rs1_fwd_i,
  input  logic                              rs1_fwd_valid_i,
  input  logic         [XLEN-1:0]           rs2_fwd_i,
  input  logic                              rs2_fwd_valid_i,
  // commit
  input  commit_port_t [NrCommitPorts-1:0]  commit_i,
  // unit readiness
  input  logic                              flu_ready_i,
  input  logic                              lsu_ready_i,
  // execute
  output fu_data_t                          fu_data_o,
  output fu_valid_t                         fu_valid_o,
  output logic         [XLEN-1:0]           pc_o,
  output logic                              is_compressed_instr_o
);

  logic [XLEN-1:0] rdata_a;
  logic [XLEN-1:0] rdata_b;
  fwd_sel_t        fwd_sel;
  logic            mult_pending;

  // ------------------------------
  // register file
  // ------------------------------
  gpr_regfile #(
    .NrCommitPorts (NrCommitPorts)
  ) i_gpr_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (issue_instr_i.rs1),
    .raddr_b_i (issue_instr_i.rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .commit_i  (commit_i)
  );

  // ------------------------------
  // hazard check
  // ------------------------------
  issue_hazard_check #(
    .NrCommitPorts (NrCommitPorts)
  ) i_issue_hazard_check (
    .issue_instr_i       (issue_instr_i),
    .issue_instr_valid_i (issue_instr_valid_i),
    .rd_clobber_i        (rd_clobber_i),
    .rs1_fwd_valid_i     (rs1_fwd_valid_i),
    .rs2_fwd_valid_i     (rs2_fwd_valid_i),
    .flu_ready_i         (flu_ready_i),
    .lsu_ready_i         (lsu_ready_i),
    .commit_i            (commit_i),
    .mult_pending_i      (mult_pending),
    .fwd_sel_o           (fwd_sel),
    .issue_ack_o         (issue_ack_o)
  );

  // ------------------------------
  // dispatch toward execute
  // ------------------------------
  operand_dispatch i_operand_dispatch (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .issue_instr_i         (issue_instr_i),
    .issue_ack_i           (issue_ack_o),
    .issue_instr_valid_i   (issue_instr_valid_i),
    .rdata_a_i             (rdata_a),
    .rdata_b_i             (rdata_b),
    .rs1_fwd_i             (rs1_fwd_i),
    .rs2_fwd_i             (rs2_fwd_i),
    .fwd_sel_i             (fwd_sel),
    .fu_data_o             (fu_data_o),
    .fu_valid_o            (fu_valid_o),
    .pc_o                  (pc_o),
    .is_compressed_instr_o (is_compressed_instr_o),
    .mult_pending_o        (mult_pending)
  );

endmodule

//--- operand_dispatch.sv
/*
 * operand selection and ID/EX pipeline registers
 * per-unit start strobes, cleared by flush
 * registered pc and compressed flag
 */

`timescale 1ns/1ps

module operand_dispatch import issue_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  // instruction and its issue decision
  input  issue_instr_t    issue_instr_i,
  input  logic            issue_ack_i,
  input  logic            issue_instr_valid_i,
  // register file data
  input  logic [XLEN-1:0] rdata_a_i,
  input  logic [XLEN-1:0] rdata_b_i,
  // scoreboard forward data
  input  logic [XLEN-1:0] rs1_fwd_i,
  input  logic [XLEN-1:0] rs2_fwd_i,
  input  fwd_sel_t        fwd_sel_i,
  // toward execute
  output fu_data_t        fu_data_o,
  output fu_valid_t       fu_valid_o,
  output logic [XLEN-1:0] pc_o,
  output logic            is_compressed_instr_o,
  output logic            mult_pending_o
);

  logic [XLEN-1:0] operand_a_d;
  logic [XLEN-1:0] operand_b_d;
  logic            issue_fire;
  fu_valid_t       fu_valid_d;
  fu_data_t        fu_data_q;
  fu_valid_t       fu_valid_q;

  // ------------------------------
  // operand select
  // ------------------------------
  always_comb begin : operand_sel
    // register file, overridden further down in rising priority
    operand_a_d = fwd_sel_i.fwd_rs1 ? rs1_fwd_i : rdata_a_i;
    operand_b_d = fwd_sel_i.fwd_rs2 ? rs2_fwd_i : rdata_b_i;
    // auipc, jal and friends
    if (issue_instr_i.use_pc) begin
      operand_a_d = issue_instr_i.pc;
    end
    // csr immediate forms, rs1 field zero-extended
    if (issue_instr_i.use_zimm) begin
      operand_a_d = {{(XLEN - REG_ADDR_W){1'b0}}, issue_instr_i.rs1};
    end
    // stores and branches keep rs2, their imm travels in the imm field
    if (issue_instr_i.use_imm && (issue_instr_i.fu != STORE) &&
        (issue_instr_i.fu != CTRL_FLOW)) begin
      operand_b_d = issue_instr_i.imm;
    end
  end

  // ------------------------------
  // strobe select
  // ------------------------------
  assign issue_fire = issue_instr_valid_i && issue_ack_i && !issue_instr_i.ex_valid;

  always_comb begin : strobe_sel
    fu_valid_d = '0;
    if (issue_fire && !flush_i) begin
      unique case (issue_instr_i.fu)
        ALU:         fu_valid_d.alu    = 1'b1;
        CTRL_FLOW:   fu_valid_d.branch = 1'b1;
        MULT:        fu_valid_d.mult   = 1'b1;
        CSR:         fu_valid_d.csr    = 1'b1;
        LOAD, STORE: fu_valid_d.lsu    = 1'b1;
        default:     fu_valid_d        = '0;
      endcase
    end
  end

  // ------------------------------
  // ID/EX registers
  // ------------------------------
  // payload follows decode every cycle, strobes say when it counts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fu_data_q             <= '{fu: NONE, operation: ADD, default: '0};
      fu_valid_q            <= '0;
      pc_o                  <= '0;
      is_compressed_instr_o <= 1'b0;
    end else begin
      fu_data_q.fu          <= issue_instr_i.fu;
      fu_data_q.operation   <= issue_instr_i.op;
      fu_data_q.operand_a   <= operand_a_d;
      fu_data_q.operand_b   <= operand_b_d;
      fu_data_q.imm         <= issue_instr_i.imm;
      fu_data_q.trans_id    <= issue_instr_i.trans_id;
      fu_valid_q            <= fu_valid_d;
      pc_o                  <= issue_instr_i.pc;
      is_compressed_instr_o <= issue_instr_i.is_compressed;
    end
  end

  assign fu_data_o      = fu_data_q;
  assign fu_valid_o     = fu_valid_q;
  // hazard check uses this to keep the fixed-latency bus free
  assign mult_pending_o = fu_valid_q.mult;

  // the hazard check must refuse alu, branch and csr right after a mult
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fu_valid_q.mult |=> !(fu_valid_q.alu || fu_valid_q.branch || fu_valid_q.csr))
    else $error("fixed-latency unit started right behind a mult");

endmodule

//--- issue_hazard_check.sv
/*
 * issue checks for the decoded instruction
 * RAW on rs1/rs2 with forward selects, WAW on rd, busy unit
 * produces issue ack in the same cycle
 */

`timescale 1ns/1ps

module issue_hazard_check import issue_pkg::*; #(
  parameter int unsigned NrCommitPorts = 2
) (
  // from decode
  input  issue_instr_t                      issue_instr_i,
  input  logic                              issue_instr_valid_i,
  // from scoreboard
  input  fu_t          [NR_REGS-1:0]        rd_clobber_i,
  input  logic                              rs1_fwd_valid_i,
  input  logic                              rs2_fwd_valid_i,
  // unit readiness
  input  logic                              flu_ready_i,
  input  logic                              lsu_ready_i,
  // writes retiring this cycle
  input  commit_port_t [NrCommitPorts-1:0]  commit_i,
  // mult strobe sitting in the ID/EX register
  input  logic                              mult_pending_i,
  output fwd_sel_t                          fwd_sel_o,
  output logic                              issue_ack_o
);

  logic stall;
  logic fu_busy;
  logic rd_free;

  // a clobbered source may be forwarded if the scoreboard has it,
  // except a CSR result, which only sfence.vma may take early
  function automatic logic can_forward(fu_t clobber, logic fwd_valid, fu_op_t op);
    return fwd_valid && ((clobber != CSR) || (op == SFENCE_VMA));
  endfunction

  // ------------------------------
  // RAW
  // ------------------------------
  always_comb begin : raw_check
    stall     = 1'b0;
    fwd_sel_o = '0;
    // rs1 field holds an immediate under zimm, nothing to wait on
    if (!issue_instr_i.use_zimm && (rd_clobber_i[issue_instr_i.rs1] != NONE)) begin
      if (can_forward(rd_clobber_i[issue_instr_i.rs1], rs1_fwd_valid_i, issue_instr_i.op)) begin
        fwd_sel_o.fwd_rs1 = 1'b1;
      end else begin
        stall = 1'b1;
      end
    end
    if (rd_clobber_i[issue_instr_i.rs2] != NONE) begin
      if (can_forward(rd_clobber_i[issue_instr_i.rs2], rs2_fwd_valid_i, issue_instr_i.op)) begin
        fwd_sel_o.fwd_rs2 = 1'b1;
      end else begin
        stall = 1'b1;
      end
    end
  end

  // ------------------------------
  // busy unit
  // ------------------------------
  always_comb begin : busy_check
    unique case (issue_instr_i.fu)
      ALU, CTRL_FLOW, MULT, CSR: fu_busy = ~flu_ready_i;
      LOAD, STORE:               fu_busy = ~lsu_ready_i;
      default:                   fu_busy = 1'b0;
    endcase
  end

  // ------------------------------
  // WAW
  // ------------------------------
  always_comb begin : waw_check
    // rd is free when no one owns it
    rd_free = (rd_clobber_i[issue_instr_i.rd] == NONE);
    // or when its owner retires right now
    for (int unsigned p = 0; p < NrCommitPorts; p++) begin
      if (commit_i[p].we && (commit_i[p].waddr == issue_instr_i.rd)) begin
        rd_free = 1'b1;
      end
    end
  end

  // ------------------------------
  // ack
  // ------------------------------
  always_comb begin : ack_gen
    issue_ack_o = 1'b0;
    if (issue_instr_valid_i) begin
      if (!stall && !fu_busy && rd_free) begin
        issue_ack_o = 1'b1;
      end
      // exceptions and unit-less instructions just pass through
      if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
        issue_ack_o = 1'b1;
      end
    end
    // fixed-latency result bus is taken by the mult one cycle behind
    if (mult_pending_i && (issue_instr_i.fu inside {ALU, CTRL_FLOW, CSR})) begin
      issue_ack_o = 1'b0;
    end
  end

endmodule

//--- gpr_regfile.sv
/*
 * integer register file, NR_REGS x XLEN flip-flops
 * two combinational read ports, NrCommitPorts write ports
 * x0 hard-wired to zero
 */

`timescale 1ns/1ps

module gpr_regfile import issue_pkg::*; #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // read ports
  input  logic         [REG_ADDR_W-1:0]     raddr_a_i,
  input  logic         [REG_ADDR_W-1:0]     raddr_b_i,
  output logic         [XLEN-1:0]           rdata_a_o,
  output logic         [XLEN-1:0]           rdata_b_o,
  // write ports from commit
  input  commit_port_t [NrCommitPorts-1:0]  commit_i
);

  logic [NR_REGS-1:0][XLEN-1:0] mem_q;

  // ------------------------------
  // write
  // ------------------------------
  // ports applied in ascending order, so the last one wins
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      for (int unsigned p = 0; p < NrCommitPorts; p++) begin
        // address 0 is never written
        if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
          mem_q[commit_i[p].waddr] <= commit_i[p].wdata;
        end
      end
    end
  end

  // ------------------------------
  // read
  // ------------------------------
  // same-cycle write is not bypassed, old value is returned
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

  // commit never retires two writers of one register together
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_port_chk
    for (genvar j = i + 1; j < NrCommitPorts; j++) begin : gen_pair_chk
      assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(commit_i[i].we && commit_i[j].we &&
          (commit_i[i].waddr == commit_i[j].waddr) && (commit_i[i].waddr != '0)))
        else $error("two commit ports write x%0d", commit_i[i].waddr);
    end
  end

endmodule

//--- issue_pkg.sv
/*
 * shared definitions for the integer issue and operand-read stage
 * widths, functional-unit and operation encodings
 * decoded instruction, commit port and execute-side structs
 */

package issue_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  // one machine word
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NR_REGS    = 32;
  // scoreboard slot id
  localparam int unsigned TRANS_ID_W = 3;

  // ------------------------------
  // encodings
  // ------------------------------
  // unit that executes an instruction, or will write a register
  typedef enum logic [2:0] {
    NONE,
    ALU,
    CTRL_FLOW,
    MULT,
    CSR,
    LOAD,
    STORE
  } fu_t;

  // operation handed to the unit
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    MUL,
    LD,
    SD,
    BEQ,
    JAL,
    CSRRW,
    SFENCE_VMA
  } fu_op_t;

  // ------------------------------
  // structs
  // ------------------------------
  // decoded instruction from decode
  typedef struct packed {
    fu_t                   fu;
    fu_op_t                op;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       pc;
    logic [TRANS_ID_W-1:0] trans_id;
    // operand b from imm
    logic                  use_imm;
    // operand a from pc
    logic                  use_pc;
    // rs1 field is an immediate, not a register
    logic                  use_zimm;
    // exception already raised upstream
    logic                  ex_valid;
    logic                  is_compressed;
  } issue_instr_t;

  // one register-file write from commit
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } commit_port_t;

  // ID/EX payload toward execute
  typedef struct packed {
    fu_t                   fu;
    fu_op_t                operation;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       imm;
    logic [TRANS_ID_W-1:0] trans_id;
  } fu_data_t;

  // one-cycle start strobes, one per unit
  typedef struct packed {
    logic alu;
    logic branch;
    logic mult;
    logic csr;
    logic lsu;
  } fu_valid_t;

  // take the scoreboard value instead of the register file
  typedef struct packed {
    logic fwd_rs1;
    logic fwd_rs2;
  } fwd_sel_t;

endpackage
